// ==== ex_unit.f ====
verilog/ex_op_pkg.sv
verilog/ex_pipe_pkg.sv
verilog/issue_router.sv
verilog/alu_fu.sv
verilog/mult_fu.sv
verilog/complete_arbiter.sv
verilog/ex_unit.sv
tb/ex_unit_assert.sv
tb/ex_unit_tb.sv

// ==== Makefile ====
# Verilator build and run of the ex_unit testbench
TOP = ex_unit_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f ex_unit.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f ex_unit.f

clean:
	rm -rf obj_dir

// ==== tb/ex_unit_tb.sv ====
////////////////////
// ex_unit testbench, rob index keys the scoreboard, max 64 in flight
// bound assertions seen through u_assert.fail_cnt
////////////////////
`timescale 1ns/100ps

module ex_unit_tb;

	logic                       clock;
	logic                       reset;
	logic                       issue_valid;
	ex_pipe_pkg::issue_pkt_t    issue_pkt;
	logic                       issue_ready;
	logic                       cdb_valid;
	ex_pipe_pkg::complete_pkt_t cdb_pkt;
	logic                       cdb_ready;
	logic [31:0]                lfsr;
	logic [5:0]                 rob_cnt;     // unique rob index source
	ex_pipe_pkg::complete_pkt_t exp_q [64];  // expected, by rob index
	bit                         pending [64];
	int                         issued;
	int                         alu_sent;    // accepted alu packets
	int                         mult_sent;
	int                         done_cnt;
	int                         stall_left;  // forced cdb_ready low cycles
	logic                       took;

	ex_unit u_ex_unit (
		.clock(clock), .reset(reset),
		.issue_valid(issue_valid), .issue_pkt(issue_pkt), .issue_ready(issue_ready),
		.cdb_valid(cdb_valid), .cdb_pkt(cdb_pkt), .cdb_ready(cdb_ready)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// taps 32,22,2,1, one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[62:0], fb};
		end
		return r;
	endfunction

	////////////////////
	// reference model
	////////////////////
	function automatic logic [63:0] ref_alu(input ex_op_pkg::alu_func_e f,
		input logic [63:0] a, input logic [63:0] b);
		case (f)
			ex_op_pkg::ALU_ADDQ:   return a + b;
			ex_op_pkg::ALU_SUBQ:   return a - b;
			ex_op_pkg::ALU_AND:    return a & b;
			ex_op_pkg::ALU_BIC:    return a & ~b;
			ex_op_pkg::ALU_BIS:    return a | b;
			ex_op_pkg::ALU_ORNOT:  return a | ~b;
			ex_op_pkg::ALU_XOR:    return a ^ b;
			ex_op_pkg::ALU_EQV:    return ~(a ^ b);
			ex_op_pkg::ALU_SRL:    return a >> b[5:0];
			ex_op_pkg::ALU_SLL:    return a << b[5:0];
			ex_op_pkg::ALU_SRA:    return $signed(a) >>> b[5:0];
			ex_op_pkg::ALU_CMPULT: return {63'd0, a < b};
			ex_op_pkg::ALU_CMPEQ:  return {63'd0, a == b};
			ex_op_pkg::ALU_CMPULE: return {63'd0, a <= b};
			ex_op_pkg::ALU_CMPLT:  return {63'd0, $signed(a) < $signed(b)};
			ex_op_pkg::ALU_CMPLE:  return {63'd0, $signed(a) <= $signed(b)};
			default:               return 64'd0;
		endcase
	endfunction

	function automatic logic ref_cond(input ex_op_pkg::br_cond_e bc, input logic [63:0] c);
		case (bc)
			ex_op_pkg::BR_LBC: return !c[0];
			ex_op_pkg::BR_EQ:  return c == 64'd0;
			ex_op_pkg::BR_LT:  return c[63];
			ex_op_pkg::BR_LE:  return c[63] || c == 64'd0;
			ex_op_pkg::BR_LBS: return c[0];
			ex_op_pkg::BR_NE:  return c != 64'd0;
			ex_op_pkg::BR_GE:  return !c[63];
			default:           return !c[63] && c != 64'd0; // gt
		endcase
	endfunction

	function automatic ex_pipe_pkg::complete_pkt_t expect_pkt(input ex_pipe_pkg::issue_pkt_t p);
		ex_pipe_pkg::complete_pkt_t e;
		logic                       tk;
		e          = '0;
		e.dest_tag = p.dest_tag;
		e.rob_idx  = p.rob_idx;
		e.pc       = p.pc;
		if (p.op_class == ex_op_pkg::OP_MULT)
			e.result = p.opa * p.opb; // low 64 bits, no branch info
		else
		begin
			tk           = p.uncond_br || (p.cond_br && ref_cond(p.br_cond, p.opc));
			e.result     = ref_alu(p.alu_func, p.opa, p.opb);
			e.is_branch  = p.uncond_br || p.cond_br;
			e.taken      = tk;
			e.mispredict = tk ^ p.pred_taken;
		end
		return e;
	endfunction

	// br is {uncond, cond, pred}
	function automatic ex_pipe_pkg::issue_pkt_t build_pkt(input ex_op_pkg::op_class_e cls,
		input ex_op_pkg::alu_func_e f, input ex_op_pkg::br_cond_e bc,
		input logic [63:0] a, input logic [63:0] b, input logic [63:0] c,
		input logic [2:0] br);
		ex_pipe_pkg::issue_pkt_t p;
		p.op_class = cls;
		p.alu_func = f;
		p.br_cond  = bc;
		p.opa      = a;
		p.opb      = b;
		p.opc      = c;
		{p.uncond_br, p.cond_br, p.pred_taken} = br;
		p.dest_tag = 6'(rand_bits(6));
		p.rob_idx  = rob_cnt;
		p.pc       = rand_bits(64);
		rob_cnt    = rob_cnt + 6'd1;
		return p;
	endfunction

	////////////////////
	// checking
	////////////////////
	task automatic give_up(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "stopping");
	endtask

	task automatic check_eq(input string what, input logic [63:0] want, input logic [63:0] got);
		assert (want === got)
		else
		begin
			$display("FAILED %s expected %h actual %h", what, want, got);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_cdb();
		ex_pipe_pkg::complete_pkt_t e;
		string                      who;
		assert (pending[cdb_pkt.rob_idx])
		else
			give_up($sformatf("completion for rob index %0d that was not issued",
				cdb_pkt.rob_idx));
		e   = exp_q[cdb_pkt.rob_idx];
		who = $sformatf("rob %0d", cdb_pkt.rob_idx);
		check_eq({who, " result"}, e.result, cdb_pkt.result);
		check_eq({who, " dest_tag"}, 64'(e.dest_tag), 64'(cdb_pkt.dest_tag));
		check_eq({who, " pc"}, e.pc, cdb_pkt.pc);
		check_eq({who, " branch/taken/mispredict"},
			64'({e.is_branch, e.taken, e.mispredict}),
			64'({cdb_pkt.is_branch, cdb_pkt.taken, cdb_pkt.mispredict}));
		pending[cdb_pkt.rob_idx] = 1'b0;
		done_cnt++;
	endtask

	// sample mid cycle, drive 2 ns after the edge
	task automatic cycle();
		@(negedge clock);
		if (u_ex_unit.u_assert.fail_cnt != 0)
			give_up("a bound protocol assertion failed");
		if (cdb_valid && cdb_ready)
			check_cdb();
		if (issue_valid && issue_ready && !took)
		begin
			exp_q[issue_pkt.rob_idx]   = expect_pkt(issue_pkt);
			pending[issue_pkt.rob_idx] = 1'b1;
			issued++;
			if (issue_pkt.op_class == ex_op_pkg::OP_MULT)
				mult_sent++;
			else
				alu_sent++;
			took = 1'b1; // transfer on the coming edge
		end
		@(posedge clock);
		#2;
		if (stall_left > 0)
		begin
			cdb_ready  = 1'b0;
			stall_left = stall_left - 1;
		end
		else
			cdb_ready = (rand_bits(2) != 64'd0); // ready 3 of 4 cycles
	endtask

	task automatic issue_one(input ex_pipe_pkg::issue_pkt_t p);
		int wait_cnt;
		issue_valid = 1'b1;
		issue_pkt   = p;
		took        = 1'b0;
		wait_cnt    = 0;
		while (!took)
			if (wait_cnt == 200)
				give_up("issue not accepted within 200 cycles");
			else
			begin
				cycle();
				wait_cnt++;
			end
		issue_valid = 1'b0;
	endtask

	task automatic drain();
		int wait_cnt;
		wait_cnt = 0;
		while (done_cnt != issued)
			if (wait_cnt == 500)
				give_up("outstanding results did not complete within 500 cycles");
			else
			begin
				cycle();
				wait_cnt++;
			end
	endtask

	////////////////////
	// stimulus
	////////////////////
	initial
	begin : stimulus
		logic [63:0] edges [3];
		logic [63:0] c;
		logic [4:0]  f5;
		lfsr        = 32'hc0c1f4bf;
		reset       = 1'b1;
		issue_valid = 1'b0;
		issue_pkt   = '0;
		cdb_ready   = 1'b0;
		rob_cnt     = 6'd0;
		issued      = 0;
		alu_sent    = 0;
		mult_sent   = 0;
		done_cnt    = 0;
		stall_left  = 0;
		took        = 1'b0;
		edges[0]    = 64'd0;
		edges[1]    = '1;
		edges[2]    = 64'h8000_0000_0000_0000; // sign bit only
		repeat (5) @(posedge clock);
		#2;
		reset     = 1'b0;
		cdb_ready = 1'b1;

		// every alu function and branch test on edge operands
		for (int f = 0; f < 16; f++)
			for (int i = 0; i < 3; i++)
				issue_one(build_pkt(ex_op_pkg::OP_ALU, ex_op_pkg::alu_func_e'(5'(f)),
					ex_op_pkg::BR_LBC, edges[i], edges[(i + 1) % 3], 64'd0, 3'b000));
		issue_one(build_pkt(ex_op_pkg::OP_ALU, ex_op_pkg::ALU_DEFAULT, ex_op_pkg::BR_LBC,
			edges[1], edges[2], 64'd0, 3'b000));
		for (int bc = 0; bc < 8; bc++)
			for (int i = 0; i < 3; i++)
				issue_one(build_pkt(ex_op_pkg::OP_ALU, ex_op_pkg::ALU_ADDQ,
					ex_op_pkg::br_cond_e'(3'(bc)), edges[i], edges[2], edges[i],
					3'(bc + i)));
		drain();

		// stall the cdb with all four units full, a fifth waits
		stall_left = 80;
		issue_one(build_pkt(ex_op_pkg::OP_ALU, ex_op_pkg::ALU_SUBQ, ex_op_pkg::BR_EQ,
			rand_bits(64), rand_bits(64), 64'd0, 3'b010));
		issue_one(build_pkt(ex_op_pkg::OP_ALU, ex_op_pkg::ALU_SRA, ex_op_pkg::BR_LT,
			edges[2], 64'd63, edges[1], 3'b011));
		issue_one(build_pkt(ex_op_pkg::OP_MULT, ex_op_pkg::ALU_DEFAULT, ex_op_pkg::BR_LBC,
			edges[1], edges[1], 64'd0, 3'b000));
		issue_one(build_pkt(ex_op_pkg::OP_MULT, ex_op_pkg::ALU_DEFAULT, ex_op_pkg::BR_LBC,
			rand_bits(64), rand_bits(64), 64'd0, 3'b000));
		issue_one(build_pkt(ex_op_pkg::OP_ALU, ex_op_pkg::ALU_CMPLT, ex_op_pkg::BR_NE,
			edges[2], edges[0], edges[0], 3'b100));
		drain();

		for (int n = 0; n < 300; n++)
		begin
			f5 = 5'(rand_bits(5));
			if (f5[4])
				f5 = (f5[3:0] == 4'hf) ? 5'h1f : {1'b0, f5[3:0]}; // rare default
			c = (rand_bits(2) == 64'd0) ? 64'd0 : rand_bits(64);
			issue_one(build_pkt(ex_op_pkg::op_class_e'(1'(rand_bits(1))),
				ex_op_pkg::alu_func_e'(f5), ex_op_pkg::br_cond_e'(3'(rand_bits(3))),
				rand_bits(64), rand_bits(64), c, 3'(rand_bits(3))));
		end
		drain();
		cycle();
		cycle();

		// router debug counters against accepted packets
		check_eq("alu issue count", 64'(alu_sent),
			64'(u_ex_unit.u_router.alu_issue_cnt));
		check_eq("mult issue count", 64'(mult_sent),
			64'(u_ex_unit.u_router.mult_issue_cnt));

		if (u_ex_unit.u_assert.fail_cnt == 0 && done_cnt == issued && !cdb_valid)
		begin
			$display("TESTS PASSED");
			$finish;
		end
		else
		begin
			$display("scoreboard not empty or a completion left over at the end");
			$display("TESTS FAILED");
			$fatal(1, "end of test check");
		end
	end

endmodule

// ==== tb/ex_unit_assert.sv ====
////////////////////
// protocol checks for ex_unit, bound by name into its scope
// fail_cnt counts failed properties
////////////////////
`timescale 1ns/100ps

module ex_unit_assert (
	input logic                       clock,
	input logic                       reset,
	input logic                       issue_valid,
	input ex_pipe_pkg::issue_pkt_t    issue_pkt,
	input logic                       issue_ready,
	input logic                       cdb_valid,
	input ex_pipe_pkg::complete_pkt_t cdb_pkt,
	input logic                       cdb_ready
);

	int fail_cnt = 0;

	////////////////////
	// back-pressure
	////////////////////
	cdb_hold: assert property (@(posedge clock) disable iff (reset)
		cdb_valid && !cdb_ready |=> cdb_valid && $stable(cdb_pkt))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("cdb_valid dropped or cdb_pkt changed while stalled");
	end

	// stimulus side of the issue handshake
	issue_hold: assert property (@(posedge clock) disable iff (reset)
		issue_valid && !issue_ready |=> issue_valid && $stable(issue_pkt))
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("issue_pkt changed before it was accepted");
	end

	// a full class stays full until the cdb takes a result
	busy_until_taken: assert property (@(posedge clock) disable iff (reset)
		issue_valid && !issue_ready && !(cdb_valid && cdb_ready) |=> !issue_ready)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("issue_ready rose with no completion on the cdb");
	end

	// first cycle out of reset
	reset_state: assert property (@(posedge clock)
		$fell(reset) |-> !cdb_valid && issue_ready)
	else
	begin
		fail_cnt = fail_cnt + 1;
		$error("wrong cdb_valid or issue_ready right after reset");
	end

endmodule

bind ex_unit ex_unit_assert u_assert (
	.clock(clock), .reset(reset),
	.issue_valid(issue_valid), .issue_pkt(issue_pkt), .issue_ready(issue_ready),
	.cdb_valid(cdb_valid), .cdb_pkt(cdb_pkt), .cdb_ready(cdb_ready)
);

// ==== verilog/ex_unit.sv ====
////////////////////
// execute stage top, two alus and two multipliers
// no flush, results leave only through the cdb handshake
////////////////////
`timescale 1ns/100ps

module ex_unit (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       issue_valid,
	input  ex_pipe_pkg::issue_pkt_t    issue_pkt,
	output logic                       issue_ready,
	output logic                       cdb_valid,
	output ex_pipe_pkg::complete_pkt_t cdb_pkt,
	input  logic                       cdb_ready
);

	logic [1:0]                       alu_busy;
	logic [1:0]                       mult_busy;
	logic [1:0]                       alu_start;
	logic [1:0]                       mult_start;
	ex_pipe_pkg::issue_pkt_t          fu_pkt;
	logic [3:0]                       res_valid;  // 0,1 alu, 2,3 mult
	ex_pipe_pkg::complete_pkt_t [3:0] res_pkt;
	logic [3:0]                       res_taken;

	issue_router u_router (
		.clock(clock), .reset(reset),
		.issue_valid(issue_valid), .issue_pkt(issue_pkt), .issue_ready(issue_ready),
		.alu_busy(alu_busy), .mult_busy(mult_busy),
		.alu_start(alu_start), .mult_start(mult_start), .fu_pkt(fu_pkt)
	);

	////////////////////
	// functional units
	////////////////////
	alu_fu u_alu0 (
		.clock(clock), .reset(reset), .start(alu_start[0]), .pkt(fu_pkt),
		.busy(alu_busy[0]), .res_valid(res_valid[0]), .res_pkt(res_pkt[0]),
		.res_taken(res_taken[0])
	);

	alu_fu u_alu1 (
		.clock(clock), .reset(reset), .start(alu_start[1]), .pkt(fu_pkt),
		.busy(alu_busy[1]), .res_valid(res_valid[1]), .res_pkt(res_pkt[1]),
		.res_taken(res_taken[1])
	);

	mult_fu u_mult0 (
		.clock(clock), .reset(reset), .start(mult_start[0]), .pkt(fu_pkt),
		.busy(mult_busy[0]), .res_valid(res_valid[2]), .res_pkt(res_pkt[2]),
		.res_taken(res_taken[2])
	);

	mult_fu u_mult1 (
		.clock(clock), .reset(reset), .start(mult_start[1]), .pkt(fu_pkt),
		.busy(mult_busy[1]), .res_valid(res_valid[3]), .res_pkt(res_pkt[3]),
		.res_taken(res_taken[3])
	);

	complete_arbiter u_arb (
		.clock(clock), .reset(reset),
		.res_valid(res_valid), .res_pkt(res_pkt), .res_taken(res_taken),
		.cdb_valid(cdb_valid), .cdb_pkt(cdb_pkt), .cdb_ready(cdb_ready)
	);

endmodule

// ==== verilog/complete_arbiter.sv ====
////////////////////
// round-robin pick of one finished unit per cycle onto the cdb
// grant is frozen while cdb_ready is low
////////////////////
`timescale 1ns/100ps

module complete_arbiter (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [3:0]                       res_valid,  // 0,1 alu, 2,3 mult
	input  ex_pipe_pkg::complete_pkt_t [3:0] res_pkt,
	output logic [3:0]                       res_taken,
	output logic                             cdb_valid,
	output ex_pipe_pkg::complete_pkt_t       cdb_pkt,
	input  logic                             cdb_ready
);

	logic [1:0] rr_ptr;   // highest priority unit
	logic [1:0] rr_idx;   // round-robin choice
	logic [1:0] lock_idx; // grant held over a stall
	logic [1:0] sel_idx;
	logic       locked;

	// first valid unit at or after rr_ptr
	always_comb
	begin : rr_search
		logic [1:0] cand;
		rr_idx = rr_ptr;
		for (int i = 3; i >= 0; i--)
		begin
			cand = rr_ptr + 2'(i); // wraps mod 4
			if (res_valid[cand])
				rr_idx = cand; // smaller offset overrides
		end
	end

	assign sel_idx   = locked ? lock_idx : rr_idx;
	assign cdb_valid = res_valid[sel_idx];
	assign cdb_pkt   = res_pkt[sel_idx];
	assign res_taken = (cdb_valid && cdb_ready) ? (4'b0001 << sel_idx) : 4'b0000;

	////////////////////
	// pointer and lock
	////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rr_ptr   <= 2'd0;
			lock_idx <= 2'd0;
			locked   <= 1'b0;
		end
		else if (cdb_valid && cdb_ready)
		begin
			rr_ptr <= sel_idx + 2'd1; // rotate past the winner
			locked <= 1'b0;
		end
		else if (cdb_valid)
		begin
			lock_idx <= sel_idx; // stalled, keep same unit
			locked   <= 1'b1;
		end
	end

endmodule

// ==== verilog/mult_fu.sv ====
////////////////////
// iterative radix-4 multiplier, low 64 bits of the product only
// result appears MULT_STEPS cycles after start, held until taken
////////////////////
`timescale 1ns/100ps

module mult_fu (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start,
	input  ex_pipe_pkg::issue_pkt_t    pkt,
	output logic                       busy,
	output logic                       res_valid,
	output ex_pipe_pkg::complete_pkt_t res_pkt,
	input  logic                       res_taken
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		HOLD
	} mult_state_e;

	mult_state_e                              state;
	logic [$clog2(ex_pipe_pkg::MULT_STEPS)-1:0] step;   // iteration count
	logic [ex_pipe_pkg::DATA_W-1:0]           mcand;    // shifts left 2 per step
	logic [ex_pipe_pkg::DATA_W-1:0]           mplier;   // shifts right 2 per step
	logic [ex_pipe_pkg::DATA_W-1:0]           prod;     // running sum
	logic [ex_pipe_pkg::DATA_W-1:0]           partial;
	logic [ex_pipe_pkg::TAG_W-1:0]            dest_tag;
	logic [ex_pipe_pkg::ROB_W-1:0]            rob_idx;
	logic [ex_pipe_pkg::DATA_W-1:0]           pc;

	// mcand times the low two multiplier bits
	always_comb
	begin
		case (mplier[1:0])
			2'b00:   partial = '0;
			2'b01:   partial = mcand;
			2'b10:   partial = mcand << 1;
			default: partial = mcand + (mcand << 1); // x3
		endcase
	end

	////////////////////
	// control
	////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= IDLE;
			step  <= '0;
		end
		else
		begin
			case (state)
				IDLE:
					if (start)
					begin
						state <= RUN;
						step  <= '0;
					end
				RUN:
				begin
					step <= step + 1'b1;
					if (int'(step) == ex_pipe_pkg::MULT_STEPS - 1)
						state <= HOLD; // last pair of bits this edge
				end
				HOLD:
					if (res_taken)
						state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////
	// datapath
	////////////////////
	always_ff @(posedge clock)
	begin
		if (start && state == IDLE)
		begin
			mcand    <= pkt.opa;
			mplier   <= pkt.opb;
			prod     <= '0;
			dest_tag <= pkt.dest_tag;
			rob_idx  <= pkt.rob_idx;
			pc       <= pkt.pc;
		end
		else if (state == RUN)
		begin
			prod   <= prod + partial; // carries past bit 63 drop
			mcand  <= mcand << 2;
			mplier <= mplier >> 2;
		end
	end

	assign busy      = (state == RUN) || (state == HOLD);
	assign res_valid = (state == HOLD);

	always_comb
	begin
		res_pkt            = '0; // no branch info from multiplies
		res_pkt.result     = prod;
		res_pkt.dest_tag   = dest_tag;
		res_pkt.rob_idx    = rob_idx;
		res_pkt.pc         = pc;
	end

endmodule

// ==== verilog/alu_fu.sv ====
////////////////////
// single cycle alu unit with branch test, result held until taken
// start must only come while busy is low
////////////////////
`timescale 1ns/100ps

module alu_fu (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       start,
	input  ex_pipe_pkg::issue_pkt_t    pkt,
	output logic                       busy,
	output logic                       res_valid,
	output ex_pipe_pkg::complete_pkt_t res_pkt,
	input  logic                       res_taken
);

	logic [ex_pipe_pkg::DATA_W-1:0] alu_result;
	logic [ex_pipe_pkg::DATA_W-1:0] sign_fill;  // sign bits for sra
	logic [5:0]                     sh;         // shift amount, opb mod 64
	logic [6:0]                     fill_sh;
	logic                           cond_ok;    // branch test on opc
	logic                           taken;
	logic                           mispredict;

	// signed less-than from an unsigned compare
	function automatic logic signed_lt(
		input logic [ex_pipe_pkg::DATA_W-1:0] a,
		input logic [ex_pipe_pkg::DATA_W-1:0] b
	);
		if (a[ex_pipe_pkg::DATA_W-1] == b[ex_pipe_pkg::DATA_W-1])
			return a < b; // same sign, plain compare
		else
			return a[ex_pipe_pkg::DATA_W-1]; // negative one is smaller
	endfunction

	////////////////////
	// alu datapath
	////////////////////
	assign sh        = pkt.opb[5:0];
	assign fill_sh   = 7'd64 - {1'b0, sh}; // 64 when sh is 0, fill drops out
	assign sign_fill = {ex_pipe_pkg::DATA_W{pkt.opa[ex_pipe_pkg::DATA_W-1]}} << fill_sh;

	always_comb
	begin
		case (pkt.alu_func)
			ex_op_pkg::ALU_ADDQ:   alu_result = pkt.opa + pkt.opb;
			ex_op_pkg::ALU_SUBQ:   alu_result = pkt.opa - pkt.opb;
			ex_op_pkg::ALU_AND:    alu_result = pkt.opa & pkt.opb;
			ex_op_pkg::ALU_BIC:    alu_result = pkt.opa & ~pkt.opb;
			ex_op_pkg::ALU_BIS:    alu_result = pkt.opa | pkt.opb;
			ex_op_pkg::ALU_ORNOT:  alu_result = pkt.opa | ~pkt.opb;
			ex_op_pkg::ALU_XOR:    alu_result = pkt.opa ^ pkt.opb;
			ex_op_pkg::ALU_EQV:    alu_result = pkt.opa ^ ~pkt.opb;
			ex_op_pkg::ALU_SRL:    alu_result = pkt.opa >> sh;
			ex_op_pkg::ALU_SLL:    alu_result = pkt.opa << sh;
			ex_op_pkg::ALU_SRA:    alu_result = (pkt.opa >> sh) | sign_fill;
			ex_op_pkg::ALU_CMPULT: alu_result = {63'd0, pkt.opa < pkt.opb};
			ex_op_pkg::ALU_CMPEQ:  alu_result = {63'd0, pkt.opa == pkt.opb};
			ex_op_pkg::ALU_CMPULE: alu_result = {63'd0, pkt.opa <= pkt.opb};
			ex_op_pkg::ALU_CMPLT:  alu_result = {63'd0, signed_lt(pkt.opa, pkt.opb)};
			ex_op_pkg::ALU_CMPLE:
				alu_result = {63'd0, signed_lt(pkt.opa, pkt.opb) | (pkt.opa == pkt.opb)};
			default:               alu_result = '0; // ALU_DEFAULT and unused codes
		endcase
	end

	////////////////////
	// branch condition
	////////////////////
	always_comb
	begin
		case (pkt.br_cond[1:0])
			2'b00:   cond_ok = ~pkt.opc[0];                 // lsb clear
			2'b01:   cond_ok = (pkt.opc == '0);             // zero
			2'b10:   cond_ok = pkt.opc[ex_pipe_pkg::DATA_W-1]; // negative
			default: cond_ok = pkt.opc[ex_pipe_pkg::DATA_W-1] | (pkt.opc == '0);
		endcase
		if (pkt.br_cond[2])
			cond_ok = ~cond_ok; // inverted tests
	end

	assign taken      = pkt.uncond_br | (pkt.cond_br & cond_ok);
	assign mispredict = taken ^ pkt.pred_taken;

	////////////////////
	// result slot
	////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
			res_valid <= 1'b0;
		else if (start)
			res_valid <= 1'b1;
		else if (res_taken)
			res_valid <= 1'b0; // free again next cycle
	end

	// payload, loaded on start only
	always_ff @(posedge clock)
	begin
		if (start)
		begin
			res_pkt.result     <= alu_result;
			res_pkt.dest_tag   <= pkt.dest_tag;
			res_pkt.rob_idx    <= pkt.rob_idx;
			res_pkt.pc         <= pkt.pc;
			res_pkt.is_branch  <= pkt.uncond_br | pkt.cond_br;
			res_pkt.taken      <= taken;
			res_pkt.mispredict <= mispredict;
		end
	end

	assign busy = res_valid; // slot full blocks new issue

endmodule

// ==== verilog/issue_router.sv ====
////////////////////
// sends one issued instruction per clock to a free unit of its class
// issue_ready only looks at busy bits, never at issue_valid
////////////////////
`timescale 1ns/100ps

module issue_router (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    issue_valid,
	input  ex_pipe_pkg::issue_pkt_t issue_pkt,
	output logic                    issue_ready,
	input  logic [1:0]              alu_busy,
	input  logic [1:0]              mult_busy,
	output logic [1:0]              alu_start,
	output logic [1:0]              mult_start,
	output ex_pipe_pkg::issue_pkt_t fu_pkt
);

	logic        is_mult; // class decode
	logic [1:0]  free;    // free units of that class
	logic [1:0]  pick;    // one-hot, lowest free
	logic        fire;
	logic [31:0] alu_issue_cnt;  // debug only
	logic [31:0] mult_issue_cnt; // debug only

	assign is_mult = (issue_pkt.op_class == ex_op_pkg::OP_MULT);
	assign free    = is_mult ? ~mult_busy : ~alu_busy;

	// unit 0 wins when both free
	assign pick = free[0] ? 2'b01 : (free[1] ? 2'b10 : 2'b00);

	assign issue_ready = |free;
	assign fire        = issue_valid & issue_ready; // transfer this edge

	assign alu_start  = (fire & ~is_mult) ? pick : 2'b00;
	assign mult_start = (fire &  is_mult) ? pick : 2'b00;
	assign fu_pkt     = issue_pkt; // both classes share the packet bus

	////////////////////
	// issue counters
	////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			alu_issue_cnt  <= '0;
			mult_issue_cnt <= '0;
		end
		else if (fire)
		begin
			if (is_mult)
				mult_issue_cnt <= mult_issue_cnt + 32'd1;
			else
				alu_issue_cnt <= alu_issue_cnt + 32'd1;
		end
	end

endmodule

// ==== verilog/ex_pipe_pkg.sv ====
////////////////////
// widths and packets between issue, units and completion bus
// rob index carries a wrap bit on top of a 32 entry index
////////////////////

package ex_pipe_pkg;

	localparam int DATA_W     = 64; // operand / result width
	localparam int TAG_W      = 6;  // 64 physical regs
	localparam int ROB_W      = 6;  // 5 bit index + wrap
	localparam int MULT_STEPS = 32; // radix-4, two bits per step

	////////////////////
	// issue side
	////////////////////
	typedef struct packed {
		ex_op_pkg::op_class_e op_class;
		ex_op_pkg::alu_func_e alu_func;
		ex_op_pkg::br_cond_e  br_cond;
		logic [DATA_W-1:0]    opa;
		logic [DATA_W-1:0]    opb;
		logic [DATA_W-1:0]    opc;        // branch test operand
		logic                 uncond_br;
		logic                 cond_br;
		logic                 pred_taken; // from front end predictor
		logic [TAG_W-1:0]     dest_tag;
		logic [ROB_W-1:0]     rob_idx;
		logic [DATA_W-1:0]    pc;
	} issue_pkt_t;

	// completion side
	typedef struct packed {
		logic [DATA_W-1:0] result;
		logic [TAG_W-1:0]  dest_tag;
		logic [ROB_W-1:0]  rob_idx;
		logic [DATA_W-1:0] pc;
		logic              is_branch;
		logic              taken;
		logic              mispredict;
	} complete_pkt_t;

endpackage

// ==== verilog/ex_op_pkg.sv ====
////////////////////
// operation encodings for the execute stage
// br_cond low two bits pick the test on opc, top bit inverts it
////////////////////

package ex_op_pkg;

	////////////////////
	// alu functions
	////////////////////
	typedef enum logic [4:0] {
		ALU_ADDQ    = 5'h00,
		ALU_SUBQ    = 5'h01,
		ALU_AND     = 5'h02,
		ALU_BIC     = 5'h03, // and-not
		ALU_BIS     = 5'h04, // or
		ALU_ORNOT   = 5'h05,
		ALU_XOR     = 5'h06,
		ALU_EQV     = 5'h07, // xor-not
		ALU_SRL     = 5'h08,
		ALU_SLL     = 5'h09,
		ALU_SRA     = 5'h0a,
		ALU_CMPULT  = 5'h0b,
		ALU_CMPEQ   = 5'h0c,
		ALU_CMPULE  = 5'h0d,
		ALU_CMPLT   = 5'h0e, // signed
		ALU_CMPLE   = 5'h0f, // signed
		ALU_DEFAULT = 5'h1f
	} alu_func_e;

	// branch tests, bit 2 set means inverted
	typedef enum logic [2:0] {
		BR_LBC = 3'b000, // lsb clear
		BR_EQ  = 3'b001, // == 0
		BR_LT  = 3'b010, // < 0
		BR_LE  = 3'b011, // <= 0
		BR_LBS = 3'b100, // lsb set
		BR_NE  = 3'b101,
		BR_GE  = 3'b110,
		BR_GT  = 3'b111
	} br_cond_e;

	typedef enum logic {
		OP_ALU  = 1'b0,
		OP_MULT = 1'b1
	} op_class_e;

endpackage
